//--- src.f
common/fifo_pkg.sv
design/ram_2p.sv
fifo/fifo_asym_converter.sv
fifo/fifo_sync.sv
design/fifo_top.sv
verification/tb_clock_gen.sv
verification/tb_fifo_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_fifo_top -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_fifo_top)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test OK"; then
   exit 0
fi
echo "pass message not found"
exit 1

//--- verification/tb_fifo_top.sv
`timescale 1ns/10ps

module tb_fifo_top
   import fifo_pkg::*;
;

   localparam int DEPTH          = 1 << ADDR_W;  // bytes
   localparam int TIMEOUT_CYCLES = 6000;

   logic    clk;
   logic    rst_n;
   logic    w_en;
   w_data_t w_data;
   logic    w_full;
   logic    r_en;
   logic    r_empty;
   r_data_t r_data;
   level_t  level;

   w_data_t     model_q[$];      // bytes in arrival order
   r_data_t     exp_data;        // last word popped by the model
   logic [31:0] rng_state;
   int          err_cnt;
   int          pass_cnt;
   int          fail_cnt;
   int          cycle_cnt;

   tb_clock_gen u_clock_gen (.clk_o(clk));

   fifo_top u_fifo_top (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .w_en_i   (w_en),
      .w_data_i (w_data),
      .w_full_o (w_full),
      .r_en_i   (r_en),
      .r_empty_o(r_empty),
      .r_data_o (r_data),
      .level_o  (level)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_data(input r_data_t exp, input r_data_t act);
      if (exp !== act) begin
         $display("MISMATCH at %0t: r_data_o expected %h got %h", $time, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_level(input level_t exp, input level_t act);
      if (exp !== act) begin
         $display("MISMATCH at %0t: level_o expected %0d got %0d", $time, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("MISMATCH at %0t: %s expected %b got %b", $time, name, exp, act);
         err_cnt++;
      end
   endtask

   // expected flags straight from the fill level
   task automatic check_outputs();
      int n;
      n = model_q.size();
      check_level(level_t'(n), level);
      check_flag("r_empty_o", n < R_INCR, r_empty);
      check_flag("w_full_o", n > DEPTH - W_INCR, w_full);
      check_data(exp_data, r_data);
   endtask

   // one clock: check, drive, update the model, move to the next drive point
   task automatic run_cycle(input logic w, input logic r, input w_data_t d);
      logic    w_acc;
      logic    r_acc;
      r_data_t word;
      int      i;
      check_outputs();
      w_acc  = w && !w_full;  // dut flags at the drive point
      r_acc  = r && !r_empty;
      w_en   = w;
      r_en   = r;
      w_data = d;
      if (r_acc) begin
         if (model_q.size() < RATIO) begin
            $display("at %0t a read was accepted with fewer than four bytes stored", $time);
            err_cnt++;
         end else begin
            word = '0;
            for (i = 0; i < RATIO; i++) begin
               word[i*W_DATA_W +: W_DATA_W] = model_q.pop_front();  // oldest byte lowest
            end
            exp_data = word;
         end
      end
      if (w_acc) begin
         if (model_q.size() >= DEPTH) begin
            $display("at %0t a write was accepted while the FIFO held %0d bytes", $time, DEPTH);
            err_cnt++;
         end else begin
            model_q.push_back(d);
         end
      end
      @(posedge clk);
      #1;
   endtask

   task automatic report_test(input string name, input int err_before);
      if (err_cnt == err_before) begin
         pass_cnt++;
         $display("[pass] %s", name);
      end else begin
         fail_cnt++;
         $display("[fail] %s, %0d errors", name, err_cnt - err_before);
      end
   endtask

   // random strobes with per-phase bias, thresholds out of 8
   task automatic random_traffic(input int cycles);
      logic [3:0] w_thr;
      logic [3:0] r_thr;
      logic       w;
      logic       r;
      int         k;
      for (k = 0; k < cycles; k++) begin
         if (k < cycles / 3) begin
            w_thr = 4'd7;  // mostly filling
            r_thr = 4'd1;
         end else if (k < 2 * cycles / 3) begin
            w_thr = 4'd2;  // mostly draining
            r_thr = 4'd5;
         end else begin
            w_thr = 4'd5;
            r_thr = 4'd2;
         end
         rng_state = xorshift32(rng_state);
         w = {1'b0, rng_state[2:0]} < w_thr;
         r = {1'b0, rng_state[5:3]} < r_thr;
         run_cycle(w, r, rng_state[15:8]);
      end
   endtask

   // watchdog
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   initial begin
      int e0;
      int i;
      rst_n     = 1'b0;
      w_en      = 1'b0;
      r_en      = 1'b0;
      w_data    = '0;
      exp_data  = '0;
      rng_state = 32'h607b3757;
      err_cnt   = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;

      e0 = err_cnt;
      check_level('0, level);
      check_flag("r_empty_o", 1'b1, r_empty);
      check_flag("w_full_o", 1'b0, w_full);
      for (i = 0; i < 3; i++) run_cycle(1'b0, 1'b1, '0);  // reads on empty
      run_cycle(1'b0, 1'b0, '0);
      report_test("after_reset", e0);

      e0 = err_cnt;
      for (i = 0; i < DEPTH; i++) begin
         rng_state = xorshift32(rng_state);
         run_cycle(1'b1, 1'b0, rng_state[7:0]);
      end
      check_level(level_t'(DEPTH), level);
      check_flag("w_full_o", 1'b1, w_full);
      for (i = 0; i < 3; i++) run_cycle(1'b1, 1'b0, 8'hee);  // dropped
      report_test("fill", e0);

      e0 = err_cnt;
      for (i = 0; i < DEPTH / RATIO; i++) run_cycle(1'b0, 1'b1, '0);
      run_cycle(1'b0, 1'b0, '0);
      check_flag("r_empty_o", 1'b1, r_empty);
      report_test("drain", e0);

      e0 = err_cnt;
      for (i = 0; i < 3; i++) run_cycle(1'b1, 1'b0, w_data_t'(8'h31 + i));
      run_cycle(1'b0, 1'b1, '0);
      run_cycle(1'b0, 1'b1, '0);
      run_cycle(1'b1, 1'b0, 8'h34);  // fourth byte
      run_cycle(1'b0, 1'b0, '0);
      run_cycle(1'b0, 1'b1, '0);
      run_cycle(1'b0, 1'b0, '0);
      report_test("partial_words", e0);

      e0 = err_cnt;
      random_traffic(1500);
      run_cycle(1'b0, 1'b0, '0);
      report_test("random_traffic", e0);

      $display("tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0 && fail_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter realtime PERIOD = 100ns
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;  // free running
   end

endmodule

//--- design/fifo_top.sv
`timescale 1ns/10ps

module fifo_top
   import fifo_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  logic    w_en_i,
   input  w_data_t w_data_i,
   output logic    w_full_o,
   input  logic    r_en_i,
   output logic    r_empty_o,
   output r_data_t r_data_o,
   output level_t  level_o
);

   // memory port between the fifo and its storage
   mem_wr_t   mem_wr;
   mem_rd_t   mem_rd;
   mem_word_t mem_rdata;

   fifo_sync u_fifo_sync (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .w_en_i     (w_en_i),
      .w_data_i   (w_data_i),
      .w_full_o   (w_full_o),
      .r_en_i     (r_en_i),
      .r_empty_o  (r_empty_o),
      .r_data_o   (r_data_o),
      .level_o    (level_o),
      .mem_wr_o   (mem_wr),
      .mem_rd_o   (mem_rd),
      .mem_rdata_i(mem_rdata)
   );

   ram_2p u_ram_2p (
      .clk_i      (clk_i),
      .mem_wr_i   (mem_wr),
      .mem_rd_i   (mem_rd),
      .mem_rdata_o(mem_rdata)
   );

endmodule

//--- fifo/fifo_sync.sv
`timescale 1ns/10ps

module fifo_sync
   import fifo_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  logic      w_en_i,
   input  w_data_t   w_data_i,
   output logic      w_full_o,
   input  logic      r_en_i,
   output logic      r_empty_o,
   output r_data_t   r_data_o,
   output level_t    level_o,
   output mem_wr_t   mem_wr_o,
   output mem_rd_t   mem_rd_o,
   input  mem_word_t mem_rdata_i
);

   localparam level_t FIFO_SIZE = level_t'(1 << ADDR_W);  // in narrow words

   logic                w_en_int;
   logic                r_en_int;
   logic [W_ADDR_W-1:0] w_addr;
   logic [R_ADDR_W-1:0] r_addr;
   level_t              level;
   level_t              level_nxt;

   // refused strobes are simply dropped
   assign w_en_int = w_en_i & ~w_full_o;
   assign r_en_int = r_en_i & ~r_empty_o;

   // address counters wrap naturally
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         w_addr <= '0;
      end else if (w_en_int) begin
         w_addr <= w_addr + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         r_addr <= '0;
      end else if (r_en_int) begin
         r_addr <= r_addr + 1'b1;
      end
   end

   // next fill level, both strobes may fire together
   always_comb begin
      level_nxt = level;
      if (w_en_int) begin
         level_nxt = level_nxt + level_t'(W_INCR);
      end
      if (r_en_int) begin
         level_nxt = level_nxt - level_t'(R_INCR);
      end
   end

   // flags come from level_nxt so they track the level register
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         level     <= '0;
         r_empty_o <= 1'b1;
         w_full_o  <= 1'b0;
      end else begin
         level     <= level_nxt;
         r_empty_o <= level_nxt < level_t'(R_INCR);  // not even one read word
         w_full_o  <= level_nxt > (FIFO_SIZE - level_t'(W_INCR));
      end
   end

   assign level_o = level;

   fifo_asym_converter u_asym_converter (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .w_en_i     (w_en_int),
      .w_addr_i   (w_addr),
      .w_data_i   (w_data_i),
      .r_en_i     (r_en_int),
      .r_addr_i   (r_addr),
      .r_data_o   (r_data_o),
      .mem_wr_o   (mem_wr_o),
      .mem_rd_o   (mem_rd_o),
      .mem_rdata_i(mem_rdata_i)
   );

endmodule

//--- fifo/fifo_asym_converter.sv
`timescale 1ns/10ps

module fifo_asym_converter
   import fifo_pkg::*;
(
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                w_en_i,
   input  logic [W_ADDR_W-1:0] w_addr_i,
   input  w_data_t             w_data_i,
   input  logic                r_en_i,
   input  logic [R_ADDR_W-1:0] r_addr_i,
   output r_data_t             r_data_o,
   output mem_wr_t             mem_wr_o,
   output mem_rd_t             mem_rd_o,
   input  mem_word_t           mem_rdata_i
);

   r_data_t rd_word;    // read word before the output hold
   logic    rd_seen_q;  // a read happened since reset

   // write path, purely combinational toward the ram
   if (W_DATA_W < R_DATA_W) begin : g_w_narrow
      logic [LANE_W-1:0] w_lane;

      assign w_lane = w_addr_i[LANE_W-1:0];

      always_comb begin
         mem_wr_o.en   = w_en_i;
         mem_wr_o.addr = w_addr_i[W_ADDR_W-1:LANE_W];
         // same byte on every lane, strobe picks the one that lands
         mem_wr_o.strb = {{(RATIO-1){1'b0}}, 1'b1} << w_lane;
         mem_wr_o.data = {RATIO{w_data_i}};
      end
   end else begin : g_w_wide
      always_comb begin
         mem_wr_o.en   = w_en_i;
         mem_wr_o.addr = w_addr_i;
         mem_wr_o.strb = '1;  // full word
         mem_wr_o.data = w_data_i;
      end
   end

   // read path, ram adds the one register stage
   if (R_DATA_W < W_DATA_W) begin : g_r_narrow
      logic [LANE_W-1:0] r_lane_q;

      always_comb begin
         mem_rd_o.en   = r_en_i;
         mem_rd_o.addr = r_addr_i[R_ADDR_W-1:LANE_W];
      end

      // lane index travels with the ram read
      always_ff @(posedge clk_i) begin
         if (!rst_n_i) begin
            r_lane_q <= '0;
         end else if (r_en_i) begin
            r_lane_q <= r_addr_i[LANE_W-1:0];
         end
      end

      assign rd_word = mem_rdata_i[r_lane_q*MIN_DATA_W +: MIN_DATA_W];
   end else begin : g_r_wide
      always_comb begin
         mem_rd_o.en   = r_en_i;
         mem_rd_o.addr = r_addr_i;
      end

      assign rd_word = mem_rdata_i;  // whole word
   end

   // ram output register holds between reads
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_seen_q <= 1'b0;
      end else if (r_en_i) begin
         rd_seen_q <= 1'b1;
      end
   end

   // zero until the first read returns
   assign r_data_o = rd_seen_q ? rd_word : '0;

endmodule

//--- design/ram_2p.sv
`timescale 1ns/10ps

module ram_2p
   import fifo_pkg::*;
(
   input  logic      clk_i,
   input  mem_wr_t   mem_wr_i,
   input  mem_rd_t   mem_rd_i,
   output mem_word_t mem_rdata_o
);

   localparam int DEPTH = 2 ** MEM_ADDR_W;

   mem_word_t mem [DEPTH];

   // lane-wise write
   always_ff @(posedge clk_i) begin
      if (mem_wr_i.en) begin
         for (int i = 0; i < RATIO; i++) begin
            if (mem_wr_i.strb[i]) begin
               mem[mem_wr_i.addr][i*MIN_DATA_W +: MIN_DATA_W] <=
                  mem_wr_i.data[i*MIN_DATA_W +: MIN_DATA_W];
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (mem_rd_i.en) begin
         mem_rdata_o <= mem[mem_rd_i.addr];  // old value kept otherwise
      end
   end

endmodule

//--- common/fifo_pkg.sv
package fifo_pkg;

   // port widths, write side narrow here (bytes in, words out)
   localparam int W_DATA_W = 8;
   localparam int R_DATA_W = 32;
   localparam int ADDR_W   = 6;  // depth in narrow words, log2

   localparam int MAX_DATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MIN_DATA_W = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W;
   localparam int RATIO      = MAX_DATA_W / MIN_DATA_W;
   localparam int LANE_W     = $clog2(RATIO);
   localparam int MEM_ADDR_W = ADDR_W - LANE_W;  // ram words

   // wide side counts ram words, narrow side counts lanes
   localparam int W_ADDR_W = (W_DATA_W == MAX_DATA_W) ? MEM_ADDR_W : ADDR_W;
   localparam int R_ADDR_W = (R_DATA_W == MAX_DATA_W) ? MEM_ADDR_W : ADDR_W;

   // level step per access, in narrow words
   localparam int W_INCR = (W_DATA_W > R_DATA_W) ? RATIO : 1;
   localparam int R_INCR = (R_DATA_W > W_DATA_W) ? RATIO : 1;

   typedef logic [W_DATA_W-1:0]   w_data_t;
   typedef logic [R_DATA_W-1:0]   r_data_t;
   typedef logic [MAX_DATA_W-1:0] mem_word_t;
   typedef logic [ADDR_W:0]       level_t;

   // write request toward the ram
   typedef struct packed {
      logic                  en;
      logic [MEM_ADDR_W-1:0] addr;
      logic [RATIO-1:0]      strb;  // one bit per narrow lane
      mem_word_t             data;
   } mem_wr_t;

   // read request, data returns a cycle later
   typedef struct packed {
      logic                  en;
      logic [MEM_ADDR_W-1:0] addr;
   } mem_rd_t;

endpackage
